/* gprFile.f */
gprPkg.sv
gprLaneBanks.sv
specialRegFile.sv
operandSelect.sv
gprFile6R3W.sv
tbGprChecker.sv
tbGprFile.sv

/* gprFile6R3W.sv */
`timescale 1ns/100ps

module gprFile6R3W #(
	parameter bit noLane3 = 1'b0
) (
	input logic clock,
	input logic rst,
	input logic hold,
	input logic gprEx3Flush,
	input gprPkg::gprValueT regInSp,
	input gprPkg::gprIdT regIdRs,		// Lane A base
	input gprPkg::gprIdT regIdRt,		// Lane A index
	input gprPkg::gprIdT regIdRu,		// Lane B base
	input gprPkg::gprIdT regIdRv,		// Lane B index / store data
	input gprPkg::gprIdT regIdRx,		// Lane C base
	input gprPkg::gprIdT regIdRy,		// Lane C index / store data
	output gprPkg::gprValueT regValRs,
	output gprPkg::gprValueT regValRt,
	output gprPkg::gprValueT regValRu,
	output gprPkg::gprValueT regValRv,
	output gprPkg::gprValueT regValRx,
	output gprPkg::gprValueT regValRy,
	input logic [gprPkg::immWidth-1:0] regValImmA,
	input logic [gprPkg::immWidth-1:0] regValImmB,
	input logic [gprPkg::immWidth-1:0] regValImmC,
	input gprPkg::gprIdT regIdRnA1,
	input gprPkg::gprValueT regValRnA1,
	input gprPkg::gprIdT regIdRnB1,
	input gprPkg::gprValueT regValRnB1,
	input gprPkg::gprIdT regIdRnC1,
	input gprPkg::gprValueT regValRnC1,
	input gprPkg::gprIdT regIdRnA2,
	input gprPkg::gprValueT regValRnA2,
	input gprPkg::gprIdT regIdRnB2,
	input gprPkg::gprValueT regValRnB2,
	input gprPkg::gprIdT regIdRnC2,
	input gprPkg::gprValueT regValRnC2,
	input gprPkg::gprIdT regIdRnA3,		// EX3 doubles as the write lanes
	input gprPkg::gprValueT regValRnA3,
	input gprPkg::gprIdT regIdRnB3,
	input gprPkg::gprValueT regValRnB3,
	input gprPkg::gprIdT regIdRnC3,
	input gprPkg::gprValueT regValRnC3,
	output gprPkg::gprValueT regOutSp,
	output gprPkg::gprValueT regOutDlr,
	output gprPkg::gprValueT regOutDhr
);
	import gprPkg::*;

	// Port order Rs, Rt, Ru, Rv, Rx, Ry
	gprIdT srcId [6];
	gprValueT bankVal [6];
	gprValueT srcVal [6];
	logic [immWidth-1:0] portImm [6];

	assign srcId = '{regIdRs, regIdRt, regIdRu, regIdRv, regIdRx, regIdRy};
	assign portImm = '{regValImmA, regValImmA, regValImmB, regValImmB, regValImmC, regValImmC};

	assign regValRs = srcVal[0];
	assign regValRt = srcVal[1];
	assign regValRu = srcVal[2];
	assign regValRv = srcVal[3];
	assign regValRx = srcVal[4];
	assign regValRy = srcVal[5];

	gprLaneBanks #(.noLane3(noLane3)) banks (
		.clock(clock),
		.rst(rst),
		.hold(hold),
		.flush(gprEx3Flush),
		.wrIdA(regIdRnA3), .wrValA(regValRnA3),
		.wrIdB(regIdRnB3), .wrValB(regValRnB3),
		.wrIdC(regIdRnC3), .wrValC(regValRnC3),
		.rdId(srcId),
		.rdVal(bankVal)
	);

	specialRegFile #(.noLane3(noLane3)) sprs (
		.clock(clock),
		.rst(rst),
		.hold(hold),
		.flush(gprEx3Flush),
		.wrIdA(regIdRnA3), .wrValA(regValRnA3),
		.wrIdB(regIdRnB3), .wrValB(regValRnB3),
		.wrIdC(regIdRnC3), .wrValC(regValRnC3),
		.regInSp(regInSp),
		.sp(regOutSp),
		.dlr(regOutDlr),
		.dhr(regOutDhr)
	);

	// Six identical read ports, each with its own forwarding network
	for (genvar p = 0; p < 6; p++)
	begin : gPort
		operandSelect #(.noLane3(noLane3)) opSel (
			.srcId(srcId[p]),
			.bankVal(bankVal[p]),
			.sp(regOutSp),
			.dlr(regOutDlr),
			.dhr(regOutDhr),
			.imm(portImm[p]),
			.dstIdA1(regIdRnA1), .dstValA1(regValRnA1),
			.dstIdB1(regIdRnB1), .dstValB1(regValRnB1),
			.dstIdC1(regIdRnC1), .dstValC1(regValRnC1),
			.dstIdA2(regIdRnA2), .dstValA2(regValRnA2),
			.dstIdB2(regIdRnB2), .dstValB2(regValRnB2),
			.dstIdC2(regIdRnC2), .dstValC2(regValRnC2),
			.dstIdA3(regIdRnA3), .dstValA3(regValRnA3),
			.dstIdB3(regIdRnB3), .dstValB3(regValRnB3),
			.dstIdC3(regIdRnC3), .dstValC3(regValRnC3),
			.srcVal(srcVal[p])
		);
	end

endmodule

/* gprLaneBanks.sv */
`timescale 1ns/100ps

module gprLaneBanks #(
	parameter bit noLane3 = 1'b0
) (
	input logic clock,
	input logic rst,
	input logic hold,
	input logic flush,
	input gprPkg::gprIdT wrIdA,			// Lane A write-back at EX3
	input gprPkg::gprValueT wrValA,
	input gprPkg::gprIdT wrIdB,			// Lane B
	input gprPkg::gprValueT wrValB,
	input gprPkg::gprIdT wrIdC,			// Lane C
	input gprPkg::gprValueT wrValC,
	input gprPkg::gprIdT rdId [6],		// One per operand port
	output gprPkg::gprValueT rdVal [6]
);
	import gprPkg::*;

	gprIdT wrId [laneCount];
	gprValueT wrVal [laneCount];
	logic [laneCount-1:0] wrEn;

	// One bank per lane, each written only by its own lane
	gprValueT bankMem [laneCount][gprCount];

	// Which bank holds the newest copy of each GPR
	logic [1:0] laneSel [gprCount];
	logic [gprCount-1:0] selIsC;		// Per-GPR flag, newest copy in bank C

	assign wrId[0] = wrIdA;
	assign wrId[1] = wrIdB;
	assign wrId[2] = wrIdC;
	assign wrVal[0] = wrValA;
	assign wrVal[1] = wrValB;
	assign wrVal[2] = wrValC;

	always_comb
	begin
		for (int l = 0; l < laneCount; l++)
			wrEn[l] = !wrId[l].fields.isSpecial;	// SP/DLR/DHR/ZZR handled elsewhere
		if (noLane3)
			wrEn[laneCount-1] = 1'b0;				// No third lane in this core
	end

	// Bank storage, frozen on hold or EX3 flush
	always_ff @(posedge clock)
	begin
		if (!hold && !flush)
		begin
			for (int l = 0; l < laneCount; l++)
			begin
				if (wrEn[l])
					bankMem[l][wrId[l].fields.gprIndex] <= wrVal[l];
			end
		end
	end

	// Lane-select update
	// Ascending lane order, so C beats B beats A on the same GPR
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			for (int g = 0; g < gprCount; g++)
				laneSel[g] <= 2'd0;			// Everything reads bank A
		end
		else if (!hold && !flush)
		begin
			for (int l = 0; l < laneCount; l++)
			begin
				if (wrEn[l])
					laneSel[wrId[l].fields.gprIndex] <= 2'(l);
			end
		end
	end

	// Read lookups, purely combinational
	for (genvar p = 0; p < 6; p++)
	begin : gRead
		logic [4:0] idx;
		assign idx = rdId[p].fields.gprIndex;
		assign rdVal[p] = bankMem[laneSel[idx]][idx];	// Newest bank for this GPR
	end

	always_comb
	begin
		for (int g = 0; g < gprCount; g++)
			selIsC[g] = (laneSel[g] == 2'd2);
	end

	// Write IDs from EX3 must be clean whenever they can commit
	assertWrIdKnown: assert property (@(posedge clock)
		!(rst || hold || flush) |-> !$isunknown({wrIdA, wrIdB, wrIdC}));

	// Two-lane build never lets a GPR point at bank C
	assertNoBankC: assert property (@(posedge clock) disable iff (rst)
		noLane3 |-> (selIsC == '0));

endmodule

/* gprPkg.sv */
package gprPkg;

	localparam int gprCount = 32;		// Architectural GPRs R0..R31
	localparam int dataWidth = 64;
	localparam int immWidth = 33;		// Decode immediate, bit 32 is sign
	localparam int laneCount = 3;		// Write-back lanes A, B, C
	localparam int stageCount = 3;		// EX1..EX3 can forward

	typedef logic [dataWidth-1:0] gprValueT;

	// Flag plus index view of a register ID
	typedef struct packed
	{
		logic isSpecial;		// Set for SP, DLR, DHR and pseudo-regs
		logic [4:0] gprIndex;	// GPR number when isSpecial clear
	} gprFieldT;

	// Same 6-bit ID word, decoded as fields or as a whole code
	typedef union packed
	{
		gprFieldT fields;
		logic [5:0] specialCode;
	} gprIdT;

	// Special codes, all with the top bit set
	localparam logic [5:0] GR_DLR = 6'h20;		// Low half of mul/div result
	localparam logic [5:0] GR_DHR = 6'h21;		// High half
	localparam logic [5:0] GR_SP = 6'h2F;		// Stack pointer
	localparam logic [5:0] GR_IMM = 6'h3E;		// Lane immediate operand
	localparam logic [5:0] GR_ZZR = 6'h3F;		// Reads zero, writes dropped

endpackage

/* operandSelect.sv */
`timescale 1ns/100ps

module operandSelect #(
	parameter bit noLane3 = 1'b0
) (
	input gprPkg::gprIdT srcId,
	input gprPkg::gprValueT bankVal,		// Newest bank copy for srcId
	input gprPkg::gprValueT sp,
	input gprPkg::gprValueT dlr,
	input gprPkg::gprValueT dhr,
	input logic [gprPkg::immWidth-1:0] imm,
	input gprPkg::gprIdT dstIdA1,
	input gprPkg::gprValueT dstValA1,
	input gprPkg::gprIdT dstIdB1,
	input gprPkg::gprValueT dstValB1,
	input gprPkg::gprIdT dstIdC1,
	input gprPkg::gprValueT dstValC1,
	input gprPkg::gprIdT dstIdA2,
	input gprPkg::gprValueT dstValA2,
	input gprPkg::gprIdT dstIdB2,
	input gprPkg::gprValueT dstValB2,
	input gprPkg::gprIdT dstIdC2,
	input gprPkg::gprValueT dstValC2,
	input gprPkg::gprIdT dstIdA3,
	input gprPkg::gprValueT dstValA3,
	input gprPkg::gprIdT dstIdB3,
	input gprPkg::gprValueT dstValB3,
	input gprPkg::gprIdT dstIdC3,
	input gprPkg::gprValueT dstValC3,
	output gprPkg::gprValueT srcVal
);
	import gprPkg::*;

	// In-flight destinations, [stage][lane], stage 0 is EX1
	gprIdT dstId [stageCount][laneCount];
	gprValueT dstVal [stageCount][laneCount];
	gprValueT baseVal;
	gprValueT immExt;
	logic pseudoReg;		// IMM or ZZR, never forwarded

	assign dstId[0][0] = dstIdA1;
	assign dstId[0][1] = dstIdB1;
	assign dstId[0][2] = dstIdC1;
	assign dstId[1][0] = dstIdA2;
	assign dstId[1][1] = dstIdB2;
	assign dstId[1][2] = dstIdC2;
	assign dstId[2][0] = dstIdA3;
	assign dstId[2][1] = dstIdB3;
	assign dstId[2][2] = dstIdC3;
	assign dstVal[0][0] = dstValA1;
	assign dstVal[0][1] = dstValB1;
	assign dstVal[0][2] = dstValC1;
	assign dstVal[1][0] = dstValA2;
	assign dstVal[1][1] = dstValB2;
	assign dstVal[1][2] = dstValC2;
	assign dstVal[2][0] = dstValA3;
	assign dstVal[2][1] = dstValB3;
	assign dstVal[2][2] = dstValC3;

	assign immExt = {{(dataWidth-immWidth){imm[immWidth-1]}}, imm};	// 33 -> 64 sign-ext

	// Base value before forwarding
	always_comb
	begin
		pseudoReg = 1'b0;
		if (!srcId.fields.isSpecial)
			baseVal = bankVal;
		else
		begin
			case (srcId.specialCode)
				GR_SP: baseVal = sp;
				GR_DLR: baseVal = dlr;
				GR_DHR: baseVal = dhr;
				GR_IMM:
				begin
					baseVal = immExt;
					pseudoReg = 1'b1;
				end
				GR_ZZR:
				begin
					baseVal = '0;
					pseudoReg = 1'b1;
				end
				default: baseVal = '0;		// Unmapped codes read zero
			endcase
		end
	end

	// Forwarding, walked oldest to youngest so EX1 lane A lands last
	always_comb
	begin
		srcVal = baseVal;
		if (!pseudoReg)
		begin
			for (int s = stageCount-1; s >= 0; s--)
			begin
				for (int l = laneCount-1; l >= 0; l--)
				begin
					if ((dstId[s][l] == srcId) && !(noLane3 && (l == laneCount-1)))
						srcVal = dstVal[s][l];
				end
			end
		end
	end

endmodule

/* runSim.sh */
#!/bin/sh
# Build the register file testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tbGprFile -f gprFile.f -o simGprFile
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simGprFile > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTBENCH PASSED$" sim.log; then
	exit 0
fi
exit 1

/* specialRegFile.sv */
`timescale 1ns/100ps

module specialRegFile #(
	parameter bit noLane3 = 1'b0
) (
	input logic clock,
	input logic rst,
	input logic hold,
	input logic flush,
	input gprPkg::gprIdT wrIdA,
	input gprPkg::gprValueT wrValA,
	input gprPkg::gprIdT wrIdB,
	input gprPkg::gprValueT wrValB,
	input gprPkg::gprIdT wrIdC,
	input gprPkg::gprValueT wrValC,
	input gprPkg::gprValueT regInSp,	// Outside SP, reloaded when no lane writes SP
	output gprPkg::gprValueT sp,
	output gprPkg::gprValueT dlr,
	output gprPkg::gprValueT dhr
);
	import gprPkg::*;

	gprIdT wrId [laneCount];
	gprValueT wrVal [laneCount];
	logic [laneCount-1:0] laneLive;
	gprValueT spNext;
	gprValueT dlrNext;
	gprValueT dhrNext;

	assign wrId[0] = wrIdA;
	assign wrId[1] = wrIdB;
	assign wrId[2] = wrIdC;
	assign wrVal[0] = wrValA;
	assign wrVal[1] = wrValB;
	assign wrVal[2] = wrValC;

	assign laneLive = noLane3 ? 3'b011 : 3'b111;	// Lane C dead in two-lane build

	// Next-state pick, later lanes override earlier ones
	always_comb
	begin
		spNext = regInSp;			// Default reload from outside
		dlrNext = dlr;
		dhrNext = dhr;
		for (int l = 0; l < laneCount; l++)
		begin
			if (laneLive[l])
			begin
				if (wrId[l].specialCode == GR_SP)
					spNext = wrVal[l];
				if (wrId[l].specialCode == GR_DLR)
					dlrNext = wrVal[l];
				if (wrId[l].specialCode == GR_DHR)
					dhrNext = wrVal[l];
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			sp <= '0;
			dlr <= '0;
			dhr <= '0;
		end
		else if (!hold && !flush)	// SP reload also frozen here
		begin
			sp <= spNext;
			dlr <= dlrNext;
			dhr <= dhrNext;
		end
	end

	// Reset clears all three, nothing may bring X back in
	assertSprKnown: assert property (@(posedge clock) disable iff (rst)
		!$isunknown({sp, dlr, dhr}));

endmodule

/* tbGprChecker.sv */
`timescale 1ns/100ps

module tbGprChecker #(
	parameter bit noLane3 = 1'b0
) (
	input logic clock,
	input logic rst,
	input logic hold,
	input logic flush,
	input gprPkg::gprValueT regInSp,
	input int testNo,						// Current test, for error lines
	input gprPkg::gprIdT srcId [6],
	input gprPkg::gprValueT srcVal [6],
	input logic [gprPkg::immWidth-1:0] imm [3],
	input gprPkg::gprIdT dstId [9],			// EX1 A/B/C, EX2 A/B/C, EX3 A/B/C
	input gprPkg::gprValueT dstVal [9],
	input gprPkg::gprValueT sp,
	input gprPkg::gprValueT dlr,
	input gprPkg::gprValueT dhr,
	output int errorCount,
	output int checkedCycles
);
	import gprPkg::*;

	// Architectural model, no banks
	gprValueT refGpr [gprCount];
	logic [gprCount-1:0] refKnown;			// Written since reset
	gprValueT refSp;
	gprValueT refDlr;
	gprValueT refDhr;
	logic [gprCount-1:0] gprTaken;			// Already won by a higher lane this edge
	logic spTaken;
	logic dlrTaken;
	logic dhrTaken;
	gprValueT expVal;
	logic expKnown;

	function automatic string testName(input int n);
		case (n)
			1: return "writeRead";
			2: return "writeConflict";
			3: return "immZero";
			4: return "forwarding";
			5: return "holdFlush";
			6: return "spReload";
			default: return "reset";
		endcase
	endfunction

	function automatic string portName(input int p);
		case (p)
			0: return "Rs";
			1: return "Rt";
			2: return "Ru";
			3: return "Rv";
			4: return "Rx";
			default: return "Ry";
		endcase
	endfunction

	// Expected operand, straight from the read rules
	function automatic gprValueT refOperand(input gprIdT id, input logic [immWidth-1:0] im,
		output logic known);
		gprValueT val;
		logic hit;
		val = '0;
		hit = 1'b0;
		known = 1'b1;
		if (id.specialCode == GR_IMM)
			val = gprValueT'($signed(im));		// Sign-extend 33 -> 64
		else if (id.specialCode != GR_ZZR)
		begin
			for (int k = 0; k < stageCount * laneCount; k++)	// EX1 A first
			begin
				if (!hit && !(noLane3 && (k % laneCount == 2))
					&& dstId[k].specialCode == id.specialCode)
				begin
					val = dstVal[k];
					hit = 1'b1;
				end
			end
			if (!hit && !id.fields.isSpecial)
			begin
				val = refGpr[id.fields.gprIndex];
				known = refKnown[id.fields.gprIndex];	// Bank unspecified until written
			end
			else if (!hit)
			begin
				case (id.specialCode)
					GR_SP: val = refSp;
					GR_DLR: val = refDlr;
					GR_DHR: val = refDhr;
					default: val = '0;
				endcase
			end
		end
		return val;
	endfunction

	initial
	begin
		errorCount = 0;
		checkedCycles = 0;
	end

	// Compare on the rising edge, then advance the model
	always @(posedge clock)
	begin
		if (!rst)
		begin
			for (int p = 0; p < 6; p++)
			begin
				expVal = refOperand(srcId[p], imm[p / 2], expKnown);
				if (expKnown && (srcVal[p] !== expVal))
				begin
					errorCount++;
					$display("** Error %s port %s id %h: expected %h, actual %h",
						testName(testNo), portName(p), srcId[p], expVal, srcVal[p]);
				end
			end
			if ({sp, dlr, dhr} !== {refSp, refDlr, refDhr})
			begin
				errorCount++;
				$display("** Error %s SP/DLR/DHR: expected %h %h %h, actual %h %h %h",
					testName(testNo), refSp, refDlr, refDhr, sp, dlr, dhr);
			end
			checkedCycles++;
		end
		if (rst)
		begin
			refSp = '0;
			refDlr = '0;
			refDhr = '0;
			refKnown = '0;
		end
		else if (!hold && !flush)
		begin
			gprTaken = '0;
			spTaken = 1'b0;
			dlrTaken = 1'b0;
			dhrTaken = 1'b0;
			for (int l = laneCount - 1; l >= 0; l--)	// C first, first writer wins
			begin
				if (!(noLane3 && l == 2))
				begin
					if (!dstId[6 + l].fields.isSpecial && !gprTaken[dstId[6 + l].fields.gprIndex])
					begin
						refGpr[dstId[6 + l].fields.gprIndex] = dstVal[6 + l];
						refKnown[dstId[6 + l].fields.gprIndex] = 1'b1;
						gprTaken[dstId[6 + l].fields.gprIndex] = 1'b1;
					end
					if (dstId[6 + l].specialCode == GR_SP && !spTaken)
					begin
						refSp = dstVal[6 + l];
						spTaken = 1'b1;
					end
					if (dstId[6 + l].specialCode == GR_DLR && !dlrTaken)
					begin
						refDlr = dstVal[6 + l];
						dlrTaken = 1'b1;
					end
					if (dstId[6 + l].specialCode == GR_DHR && !dhrTaken)
					begin
						refDhr = dstVal[6 + l];
						dhrTaken = 1'b1;
					end
				end
			end
			if (!spTaken)
				refSp = regInSp;		// Reload from outside
		end
	end

endmodule

/* tbGprFile.sv */
`timescale 1ns/100ps

module tbGprFile;
	import gprPkg::*;

	localparam bit noLane3 = 1'b0;
	localparam int resetCycles = 10;
	localparam int lenWriteRead = gprCount * laneCount * 2;	// Write cycle plus read cycle
	localparam int lenConflict = 40;
	localparam int lenImmZero = 20;
	localparam int lenForward = 200;
	localparam int lenHoldFlush = 40;
	localparam int lenSpReload = 30;
	localparam int cycleLimit = resetCycles + lenWriteRead + lenConflict + lenImmZero
		+ lenForward + lenHoldFlush + lenSpReload + 100;

	logic clock = 1'b0;
	logic rst;
	logic hold;
	logic flush;
	gprValueT regInSp;
	gprIdT srcId [6];					// Rs, Rt, Ru, Rv, Rx, Ry
	gprValueT srcVal [6];
	logic [immWidth-1:0] imm [3];		// Lanes A, B, C
	gprIdT dstId [9];					// EX1 A/B/C, EX2 A/B/C, EX3 A/B/C
	gprValueT dstVal [9];
	gprValueT sp;
	gprValueT dlr;
	gprValueT dhr;
	int testNo;
	int errorCount;
	int checkedCycles;
	int cycleCount = 0;
	logic [31:0] rngState;

	always #5 clock = ~clock;

	gprFile6R3W #(.noLane3(noLane3)) dut0 (
		.clock(clock), .rst(rst), .hold(hold), .gprEx3Flush(flush), .regInSp(regInSp),
		.regIdRs(srcId[0]), .regIdRt(srcId[1]), .regIdRu(srcId[2]),
		.regIdRv(srcId[3]), .regIdRx(srcId[4]), .regIdRy(srcId[5]),
		.regValRs(srcVal[0]), .regValRt(srcVal[1]), .regValRu(srcVal[2]),
		.regValRv(srcVal[3]), .regValRx(srcVal[4]), .regValRy(srcVal[5]),
		.regValImmA(imm[0]), .regValImmB(imm[1]), .regValImmC(imm[2]),
		.regIdRnA1(dstId[0]), .regValRnA1(dstVal[0]),
		.regIdRnB1(dstId[1]), .regValRnB1(dstVal[1]),
		.regIdRnC1(dstId[2]), .regValRnC1(dstVal[2]),
		.regIdRnA2(dstId[3]), .regValRnA2(dstVal[3]),
		.regIdRnB2(dstId[4]), .regValRnB2(dstVal[4]),
		.regIdRnC2(dstId[5]), .regValRnC2(dstVal[5]),
		.regIdRnA3(dstId[6]), .regValRnA3(dstVal[6]),
		.regIdRnB3(dstId[7]), .regValRnB3(dstVal[7]),
		.regIdRnC3(dstId[8]), .regValRnC3(dstVal[8]),
		.regOutSp(sp), .regOutDlr(dlr), .regOutDhr(dhr)
	);

	tbGprChecker #(.noLane3(noLane3)) monitor0 (
		.clock(clock), .rst(rst), .hold(hold), .flush(flush), .regInSp(regInSp),
		.testNo(testNo), .srcId(srcId), .srcVal(srcVal), .imm(imm),
		.dstId(dstId), .dstVal(dstVal), .sp(sp), .dlr(dlr), .dhr(dhr),
		.errorCount(errorCount), .checkedCycles(checkedCycles)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] nextRandom();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	function automatic gprValueT randomValue();
		return {nextRandom(), nextRandom()};
	endfunction

	function automatic logic [immWidth-1:0] randomImm();
		logic [63:0] raw;
		raw = {nextRandom(), nextRandom()};
		return raw[immWidth-1:0];		// Sign bit random too
	endfunction

	function automatic gprIdT gprId(input int r);
		gprIdT id;
		id.fields.isSpecial = 1'b0;
		id.fields.gprIndex = 5'(r);
		return id;
	endfunction

	// Mostly a small set so forwarding hits often
	function automatic gprIdT pickId();
		int sel;
		gprIdT id;
		sel = int'(nextRandom() % 32'd10);
		case (sel)
			0, 1, 2: id = gprId(sel + 1);
			3: id = GR_SP;
			4: id = GR_DLR;
			5: id = GR_DHR;
			6: id = GR_ZZR;
			7: id = GR_IMM;
			default: id = gprId(int'(nextRandom() % 32'd32));
		endcase
		return id;
	endfunction

	task automatic clearPorts();
		for (int p = 0; p < 6; p++)
			srcId[p] = GR_ZZR;
		for (int k = 0; k < 9; k++)
		begin
			dstId[k] = GR_ZZR;
			dstVal[k] = '0;
		end
	endtask

	task automatic randomizePorts();
		for (int p = 0; p < 6; p++)
			srcId[p] = pickId();
		for (int k = 0; k < 9; k++)
		begin
			dstId[k] = pickId();
			dstVal[k] = randomValue();
		end
		for (int i = 0; i < 3; i++)
			imm[i] = randomImm();
		regInSp = randomValue();
	endtask

	// Every GPR through every lane and read back next cycle
	task automatic writeThenReadAll();
		for (int r = 0; r < gprCount; r++)
		begin
			for (int l = 0; l < laneCount; l++)
			begin
				@(negedge clock);
				testNo = 1;
				clearPorts();
				dstId[6 + l] = gprId(r);
				dstVal[6 + l] = randomValue();
				@(negedge clock);
				clearPorts();
				for (int p = 0; p < 6; p++)
					srcId[p] = gprId(r);
			end
		end
	endtask

	task automatic conflictingWrites();
		int r;
		logic [2:0] mask;
		for (int i = 0; i < lenConflict / 2; i++)
		begin
			r = int'(nextRandom() % 32'd32);
			case (nextRandom() % 32'd4)
				0: mask = 3'b011;
				1: mask = 3'b101;
				2: mask = 3'b110;
				default: mask = 3'b111;
			endcase
			@(negedge clock);
			testNo = 2;
			clearPorts();
			for (int l = 0; l < laneCount; l++)
			begin
				if (mask[l])
				begin
					dstId[6 + l] = gprId(r);
					dstVal[6 + l] = randomValue();
				end
			end
			@(negedge clock);
			clearPorts();
			for (int p = 0; p < 6; p++)
				srcId[p] = gprId(r);
		end
	endtask

	// Pseudo regs against pseudo-reg destinations with live values
	task automatic immAndZeroReads();
		for (int i = 0; i < lenImmZero; i++)
		begin
			@(negedge clock);
			testNo = 3;
			for (int p = 0; p < 6; p++)
				srcId[p] = ((nextRandom() & 32'd1) != 0) ? GR_IMM : GR_ZZR;
			for (int k = 0; k < 9; k++)
			begin
				dstId[k] = ((nextRandom() & 32'd1) != 0) ? GR_IMM : GR_ZZR;
				dstVal[k] = randomValue();
			end
			for (int j = 0; j < 3; j++)
				imm[j] = randomImm();
		end
	endtask

	task automatic driveRandomCycles(input int n, input int tn);
		for (int i = 0; i < n; i++)
		begin
			@(negedge clock);
			testNo = tn;
			randomizePorts();
			if (tn == 5)
			begin
				hold = (i % 4 == 1) || (i % 4 == 3);	// Walks none, hold, flush and both
				flush = (i % 4 == 2) || (i % 4 == 3);
			end
		end
	endtask

	task automatic spReloadSequence();
		for (int i = 0; i < lenSpReload; i++)
		begin
			@(negedge clock);
			testNo = 6;
			clearPorts();
			hold = 1'b0;
			flush = 1'b0;
			regInSp = randomValue();
			if (i % 3 == 2)
			begin
				dstId[6 + int'(nextRandom() % 32'd3)] = GR_SP;	// Lane write beats reload
				dstVal[6] = randomValue();
				dstVal[7] = randomValue();
				dstVal[8] = randomValue();
			end
			for (int p = 0; p < 6; p++)
				srcId[p] = (p < 3) ? GR_SP : GR_DLR;
		end
	endtask

	// Run limit
	always @(posedge clock)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("Errors: %0d over %0d checked cycles", errorCount, checkedCycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial
	begin
		rngState = 32'd77763;
		rst = 1'b1;
		hold = 1'b0;
		flush = 1'b0;
		regInSp = '0;
		testNo = 0;
		for (int i = 0; i < 3; i++)
			imm[i] = '0;
		clearPorts();
		repeat (resetCycles) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
		writeThenReadAll();
		conflictingWrites();
		immAndZeroReads();
		driveRandomCycles(lenForward, 4);
		driveRandomCycles(lenHoldFlush, 5);
		spReloadSequence();
		@(negedge clock);		// Last stimulus checked at the edge in between
		$display("Errors: %0d over %0d checked cycles", errorCount, checkedCycles);
		if (errorCount == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
